//--- source/mod_settings.svh
`ifndef MOD_SETTINGS_SVH
`define MOD_SETTINGS_SVH

// Width of one DAC sample, and of one serial frame in bits.
`define MOD_SAMPLE_BITS 16

// Sample FIFO between the generator and the serializer.
`define MOD_FIFO_DEPTH 8

`define MOD_RESET_COUNT 125 // Count of the first low half-period after reset.

// Idle cycles with sync high between two serial frames.
`define DAC_GAP_CYCLES 2

`endif

//--- source/mod_pkg.sv
`include "mod_settings.svh"

package mod_pkg;

    // One signed DAC code, as written by the generator and shifted out by the serializer.
    typedef logic signed [`MOD_SAMPLE_BITS-1:0] mod_sample_t;

    // Level of the square wave. The value equals the status pin.
    typedef enum logic {
        LEVEL_LOW  = 1'b0,
        LEVEL_HIGH = 1'b1
    } mod_level_e;

endpackage : mod_pkg

//--- source/dac_pkg.sv
`include "mod_settings.svh"

package dac_pkg;

    // Frame sequencing of the serial DAC link.
    typedef enum logic [1:0] {
        DAC_IDLE  = 2'd0, // Waiting for a sample.
        DAC_SHIFT = 2'd1, // Sync low, bits going out.
        DAC_GAP   = 2'd2  // Sync high before the next frame.
    } dac_state_e;

    // Counts the bits of one frame, MSB first.
    typedef logic [$clog2(`MOD_SAMPLE_BITS)-1:0] dac_bit_idx_t;

endpackage : dac_pkg

//--- source/square_mod_gen.sv
`timescale 1ns/1ps
`include "mod_settings.svh"

module square_mod_gen
    import mod_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [31:0]                 i_freq_cnt,
    input  logic [`MOD_SAMPLE_BITS-1:0] i_amp_high,
    input  logic [`MOD_SAMPLE_BITS-1:0] i_amp_low,
    input  logic [31:0]                 i_ramp_trig_cnt,
    output mod_sample_t                 o_sample,
    output logic                        o_sample_wr,
    output logic                        o_status,
    output logic                        o_step_trig
);

    mod_level_e  level;
    logic [31:0] half_cnt;
    logic [31:0] trig_div;
    logic        level_edge;

    // The status register trails the level by one cycle, so a mismatch
    // marks the first cycle of a half-period loaded from i_freq_cnt.
    assign level_edge = (level != mod_level_e'(o_status));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            level    <= LEVEL_LOW;
            half_cnt <= 32'(`MOD_RESET_COUNT);
        end else begin
            case (level)
                LEVEL_LOW: begin
                    if (half_cnt != 32'd0) begin
                        half_cnt <= half_cnt - 32'd1;
                    end else begin
                        level    <= LEVEL_HIGH;
                        half_cnt <= i_freq_cnt;
                    end
                end
                default: begin
                    // High ends at one, so it lasts one cycle less than low.
                    if (half_cnt > 32'd1) begin
                        half_cnt <= half_cnt - 32'd1;
                    end else begin
                        level    <= LEVEL_LOW;
                        half_cnt <= i_freq_cnt;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_status    <= 1'b0;
            o_sample_wr <= 1'b0;
            o_step_trig <= 1'b0;
            trig_div    <= 32'd0;
        end else begin
            o_status    <= level;
            o_sample_wr <= level_edge; // Lands together with the new sample.
            o_step_trig <= 1'b0;
            if (level_edge) begin
                if (trig_div == 32'd0) begin
                    o_step_trig <= 1'b1;
                    trig_div    <= i_ramp_trig_cnt;
                end else begin
                    trig_div <= trig_div - 32'd1;
                end
            end
        end
    end

    // Follows the amplitude of the current level. The FIFO only takes it on the strobe.
    always_ff @(posedge i_clk) begin
        if (level == LEVEL_HIGH) begin
            o_sample <= mod_sample_t'(i_amp_high);
        end else begin
            o_sample <= mod_sample_t'(i_amp_low);
        end
    end

endmodule : square_mod_gen

//--- source/sample_fifo.sv
`timescale 1ns/1ps
`include "mod_settings.svh"

module sample_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `MOD_FIFO_DEPTH
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_wr,
    input  payload_t i_wr_data,
    input  logic     i_rd,
    output payload_t o_rd_data,
    output logic     o_empty,
    output logic     o_full,
    output logic     o_overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign o_empty   = (count == '0);
    assign o_full    = (count == CNT_W'(DEPTH));
    assign do_wr     = i_wr && !o_full; // A write into a full FIFO is dropped.
    assign do_rd     = i_rd && !o_empty;
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_wr) wr_ptr <= next_ptr(wr_ptr);
            if (do_rd) rd_ptr <= next_ptr(rd_ptr);
            if (do_wr && !do_rd) begin
                count <= count + CNT_W'(1);
            end else if (do_rd && !do_wr) begin
                count <= count - CNT_W'(1);
            end
            if (i_wr && o_full) o_overflow <= 1'b1; // Sticky until reset.
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) mem[wr_ptr] <= i_wr_data;
    end

    a_no_read_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rd |-> !o_empty)
        else $error("sample_fifo: read while empty.");

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        count <= CNT_W'(DEPTH))
        else $error("sample_fifo: occupancy above depth.");

endmodule : sample_fifo

//--- source/dac_serializer.sv
`timescale 1ns/1ps
`include "mod_settings.svh"

module dac_serializer
    import mod_pkg::*;
    import dac_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_empty,
    input  mod_sample_t i_sample,
    output logic        o_pop,
    output logic        o_dac_sync_n,
    output logic        o_dac_sclk,
    output logic        o_dac_sdo
);

    localparam int FRAME_CYCLES = 2 * `MOD_SAMPLE_BITS;
    localparam int GAP_W        = $clog2(`DAC_GAP_CYCLES + 1);

    dac_state_e       state;
    dac_bit_idx_t     bit_idx;
    logic             phase; // High in the second cycle of a bit.
    logic [GAP_W-1:0] gap_cnt;
    mod_sample_t      shreg;

    // The head sample is taken on the same cycle as the pop.
    assign o_pop     = (state == DAC_IDLE) && !i_empty;
    assign o_dac_sdo = shreg[`MOD_SAMPLE_BITS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= DAC_IDLE;
            bit_idx      <= '0;
            phase        <= 1'b0;
            gap_cnt      <= '0;
            shreg        <= '0;
            o_dac_sync_n <= 1'b1;
            o_dac_sclk   <= 1'b0;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (o_pop) begin
                        state        <= DAC_SHIFT;
                        shreg        <= i_sample;
                        bit_idx      <= '0;
                        phase        <= 1'b0;
                        o_dac_sync_n <= 1'b0;
                    end
                end
                DAC_SHIFT: begin
                    phase      <= !phase;
                    o_dac_sclk <= !phase; // The DAC samples on this rising edge.
                    if (phase) begin
                        if (bit_idx == dac_bit_idx_t'(`MOD_SAMPLE_BITS - 1)) begin
                            state        <= DAC_GAP;
                            o_dac_sync_n <= 1'b1;
                            gap_cnt      <= GAP_W'(`DAC_GAP_CYCLES - 1);
                        end else begin
                            bit_idx <= bit_idx + dac_bit_idx_t'(1);
                            shreg   <= shreg << 1; // Next bit appears while SCLK is low.
                        end
                    end
                end
                DAC_GAP: begin
                    if (gap_cnt == '0) begin
                        state <= DAC_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt - GAP_W'(1);
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    a_sync_frame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(o_dac_sync_n) |-> (!o_dac_sync_n) [*FRAME_CYCLES] ##1 o_dac_sync_n)
        else $error("dac_serializer: sync low length is not one frame.");

endmodule : dac_serializer

//--- source/mod_dac_top.sv
`timescale 1ns/1ps
`include "mod_settings.svh"

module mod_dac_top
    import mod_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic [31:0]                 i_freq_cnt,
    input  logic [`MOD_SAMPLE_BITS-1:0] i_amp_high,
    input  logic [`MOD_SAMPLE_BITS-1:0] i_amp_low,
    input  logic [31:0]                 i_ramp_trig_cnt,
    output logic                        o_status,
    output logic                        o_step_trig,
    output logic                        o_dac_sync_n,
    output logic                        o_dac_sclk,
    output logic                        o_dac_sdo,
    output logic                        o_overflow
);

    mod_sample_t gen_sample;
    logic        gen_sample_wr;
    mod_sample_t fifo_head;
    logic        fifo_empty;
    logic        ser_pop;

    square_mod_gen square_mod_gen_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_freq_cnt      (i_freq_cnt),
        .i_amp_high      (i_amp_high),
        .i_amp_low       (i_amp_low),
        .i_ramp_trig_cnt (i_ramp_trig_cnt),
        .o_sample        (gen_sample),
        .o_sample_wr     (gen_sample_wr),
        .o_status        (o_status),
        .o_step_trig     (o_step_trig)
    );

    // No back-pressure toward the generator. The FULL flag is only used inside the FIFO.
    sample_fifo #(
        .payload_t (mod_sample_t),
        .DEPTH     (`MOD_FIFO_DEPTH)
    ) sample_fifo_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (gen_sample_wr),
        .i_wr_data  (gen_sample),
        .i_rd       (ser_pop),
        .o_rd_data  (fifo_head),
        .o_empty    (fifo_empty),
        .o_full     (),
        .o_overflow (o_overflow)
    );

    dac_serializer dac_serializer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_empty      (fifo_empty),
        .i_sample     (fifo_head),
        .o_pop        (ser_pop),
        .o_dac_sync_n (o_dac_sync_n),
        .o_dac_sclk   (o_dac_sclk),
        .o_dac_sdo    (o_dac_sdo)
    );

endmodule : mod_dac_top

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk; // 20 ns period.
    end

    // Reset is held for 5 clock cycles at start and again on every request.
    initial begin
        o_rst_n = 1'b0;
        forever begin
            repeat (5) @(posedge o_clk);
            #2 o_rst_n = 1'b1;
            do @(posedge o_clk); while (!i_rst_req);
            #2 o_rst_n = 1'b0;
        end
    end

endmodule : tb_clk_gen

//--- dv/tb_mod_dac_top.sv
`timescale 1ns/1ps
`include "mod_settings.svh"

module tb_mod_dac_top
    import mod_pkg::*;
();

    localparam int N_TESTS      = 5;
    localparam int SAMPLE_BITS  = `MOD_SAMPLE_BITS;
    localparam int FRAME_CYCLES = 2 * `MOD_SAMPLE_BITS + `DAC_GAP_CYCLES + 1;
    localparam int T_FRAMES     = 0;
    localparam int T_LEVELS     = 1;
    localparam int T_TRIGGER    = 2;
    localparam int T_UPDATE     = 3;
    localparam int T_OVERFLOW   = 4;

    logic                   clk;
    logic                   rst_n;
    logic                   rst_req;
    logic [31:0]            freq_cnt;
    logic [SAMPLE_BITS-1:0] amp_high;
    logic [SAMPLE_BITS-1:0] amp_low;
    logic [31:0]            ramp_trig_cnt;
    logic                   status;
    logic                   step_trig;
    logic                   dac_sync_n;
    logic                   dac_sclk;
    logic                   dac_sdo;
    logic                   overflow;

    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          watchdog_ns;
    mod_sample_t exp_q[$];
    mod_sample_t got_q[$];
    event        frame_done;

    // Monitor state, cleared while reset is low.
    logic        prev_status;
    logic        prev_sclk;
    logic        prev_sync;
    mod_sample_t prev_amp_high;
    mod_sample_t prev_amp_low;
    mod_sample_t shift_word;
    int          bit_cnt;
    int          edge_idx;
    int          level_cycles;
    int          durations_checked;
    int          trig_pulses;
    int          frames_checked;
    int          neg_frames;
    logic        overflow_seen;
    logic        drops_allowed;
    logic        overflow_expected;

    int          cfg_freq[N_TESTS];
    int          cfg_trig[N_TESTS];
    int          cfg_frames[N_TESTS];
    mod_sample_t cfg_amp_hi[N_TESTS];
    mod_sample_t cfg_amp_lo[N_TESTS];
    mod_sample_t upd_amp_hi;
    mod_sample_t upd_amp_lo;
    string       test_name[N_TESTS];

    tb_clk_gen tb_clk_gen_i (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst_n   (rst_n)
    );

    mod_dac_top mod_dac_top_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_freq_cnt      (freq_cnt),
        .i_amp_high      (amp_high),
        .i_amp_low       (amp_low),
        .i_ramp_trig_cnt (ramp_trig_cnt),
        .o_status        (status),
        .o_step_trig     (step_trig),
        .o_dac_sync_n    (dac_sync_n),
        .o_dac_sclk      (dac_sclk),
        .o_dac_sdo       (dac_sdo),
        .o_overflow      (overflow)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // The n-th level change after reset carries the amplitude of the level it enters.
    function automatic mod_sample_t expected_word(input mod_sample_t amp_hi,
                                                  input mod_sample_t amp_lo,
                                                  input logic start_high, input int idx);
        logic high;
        high = start_high ^ (idx % 2 == 1);
        return high ? amp_hi : amp_lo;
    endfunction

    // Length of the half-period that ends with level change idx.
    function automatic int expected_half_cycles(input int freq, input int idx);
        if (idx == 0) begin
            return `MOD_RESET_COUNT + 1;
        end
        return (idx % 2 == 1) ? freq : freq + 1;
    endfunction

    function automatic logic trigger_due(input int trig_cnt, input int idx);
        return (idx % (trig_cnt + 1)) == 0; // Divider starts at zero, so change 0 fires.
    endfunction

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("FAILED at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic wait_status_edges(input int n);
        do @(posedge clk); while (edge_idx < n);
        #2;
    endtask

    task automatic wait_frames(input int n);
        do @(posedge clk); while (frames_checked < n);
        #2;
    endtask

    task automatic restart_dut(input int t);
        @(posedge clk);
        #2;
        rst_req = 1'b1;
        wait (rst_n === 1'b0);
        freq_cnt          = cfg_freq[t];
        ramp_trig_cnt     = cfg_trig[t];
        amp_high          = cfg_amp_hi[t];
        amp_low           = cfg_amp_lo[t];
        drops_allowed     = (t == T_OVERFLOW);
        overflow_expected = (t == T_OVERFLOW);
        @(posedge clk);
        #2;
        rst_req = 1'b0;
        wait (rst_n === 1'b1);
    endtask

    // Level, trigger and frame monitor. All outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            got_q.delete();
            bit_cnt           = 0;
            edge_idx          = 0;
            level_cycles      = -1; // The generator counts from the first edge after release.
            durations_checked = 0;
            trig_pulses       = 0;
            frames_checked    = 0;
            neg_frames        = 0;
            overflow_seen     = 1'b0;
            shift_word        = '0;
        end else begin
            if (status != prev_status) begin
                check(level_cycles == expected_half_cycles(freq_cnt, edge_idx),
                      $sformatf("half-period %0d lasted %0d cycles, expected %0d", edge_idx,
                                level_cycles, expected_half_cycles(freq_cnt, edge_idx)));
                check(status == (edge_idx % 2 == 0),
                      $sformatf("level change %0d went to the wrong level", edge_idx));
                exp_q.push_back(expected_word(prev_amp_high, prev_amp_low, 1'b1, edge_idx));
                durations_checked++;
                level_cycles = 1;
            end else begin
                level_cycles++;
            end
            if ((status != prev_status) || step_trig) begin
                check(step_trig == ((status != prev_status) &&
                                    trigger_due(ramp_trig_cnt, edge_idx)),
                      $sformatf("step trigger is %0b at level change %0d", step_trig, edge_idx));
            end
            if (step_trig) trig_pulses++;
            if (status != prev_status) edge_idx++;

            if (overflow_seen || (!overflow_expected && overflow)) begin
                check(overflow_expected && overflow, "overflow flag in the wrong state");
            end
            overflow_seen = overflow_seen | overflow;

            // Serial frame decoder.
            if (!dac_sync_n && prev_sync) begin
                bit_cnt    = 0;
                shift_word = '0;
            end
            if (!dac_sync_n && dac_sclk && !prev_sclk) begin
                shift_word = {shift_word[SAMPLE_BITS-2:0], dac_sdo};
                bit_cnt++;
            end
            if (dac_sync_n && !prev_sync) begin
                check(bit_cnt == SAMPLE_BITS,
                      $sformatf("frame held %0d bits, expected %0d", bit_cnt, SAMPLE_BITS));
                got_q.push_back(shift_word);
                -> frame_done;
            end
        end
        prev_status   = status;
        prev_sclk     = dac_sclk;
        prev_sync     = dac_sync_n;
        prev_amp_high = amp_high;
        prev_amp_low  = amp_low;
    end

    initial begin : compare
        mod_sample_t word;
        mod_sample_t want;
        logic        found;
        forever begin
            @(frame_done);
            while (got_q.size() != 0) begin
                word = got_q.pop_front();
                if (drops_allowed) begin
                    // Dropped writes leave gaps, but the order must hold.
                    while (exp_q.size() != 0 && exp_q[0] != word) begin
                        void'(exp_q.pop_front());
                    end
                end
                found = (exp_q.size() != 0) && (exp_q[0] == word);
                want  = (exp_q.size() != 0) ? exp_q[0] : '0;
                check(found, $sformatf("frame %0d carried %0d, expected %0d",
                                       frames_checked, word, want));
                if (found && word < 0) neg_frames++;
                if (exp_q.size() != 0) void'(exp_q.pop_front());
                frames_checked++;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns.", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        int          limit_cycles;
        int          err_start;
        int          n;
        errors            = 0;
        checks            = 0;
        watchdog_ns       = 0;
        rst_req           = 1'b0;
        freq_cnt          = 32'd40;
        amp_high          = '0;
        amp_low           = '0;
        ramp_trig_cnt     = '0;
        drops_allowed     = 1'b0;
        overflow_expected = 1'b0;
        rng_state         = 32'h3142da0e;
        test_name[T_FRAMES]   = "frame contents";
        test_name[T_LEVELS]   = "level durations";
        test_name[T_TRIGGER]  = "trigger spacing";
        test_name[T_UPDATE]   = "amplitude update";
        test_name[T_OVERFLOW] = "overflow";

        for (int t = 0; t < N_TESTS; t++) begin
            r = next_random();
            cfg_freq[t] = 40 + (r % 61);
            r = next_random();
            cfg_trig[t] = r % 4;
            r = next_random();
            cfg_amp_hi[t] = r[SAMPLE_BITS-1:0];
            r = next_random();
            cfg_amp_lo[t] = r[SAMPLE_BITS-1:0];
            cfg_frames[t] = 8;
        end
        cfg_frames[T_LEVELS] = 6;
        r = next_random();
        cfg_trig[T_TRIGGER]   = 1 + (r % 3);
        cfg_frames[T_TRIGGER] = 12;
        cfg_amp_hi[T_UPDATE][SAMPLE_BITS-1] = 1'b0; // Positive before the update.
        cfg_amp_lo[T_UPDATE][SAMPLE_BITS-1] = 1'b0;
        cfg_frames[T_UPDATE] = 10;
        r = next_random();
        upd_amp_hi = r[SAMPLE_BITS-1:0] | 16'h8000;
        r = next_random();
        upd_amp_lo = r[SAMPLE_BITS-1:0] | 16'h8000;
        cfg_freq[T_OVERFLOW] = 10;
        cfg_trig[T_OVERFLOW] = 1;

        limit_cycles = 100;
        for (int t = 0; t < N_TESTS; t++) begin
            limit_cycles += 20 + `MOD_RESET_COUNT + 10;
            limit_cycles += (cfg_frames[t] + 2) *
                            (((cfg_freq[t] > FRAME_CYCLES) ? cfg_freq[t] : FRAME_CYCLES) + 2);
        end
        watchdog_ns = limit_cycles * 20;

        wait (rst_n === 1'b1);
        for (int t = 0; t < N_TESTS; t++) begin
            err_start = errors;
            restart_dut(t);
            case (t)
                T_UPDATE: begin
                    wait_status_edges(3);
                    amp_high = upd_amp_hi;
                    amp_low  = upd_amp_lo;
                    wait_frames(cfg_frames[t]);
                    check(neg_frames > 0, "no negative amplitude came through the DAC link");
                end
                T_OVERFLOW: begin
                    n = 1;
                    while (frames_checked < cfg_frames[t]) begin
                        wait_status_edges(n);
                        r = next_random();
                        amp_high = r[SAMPLE_BITS-1:0];
                        amp_low  = r[31:32-SAMPLE_BITS];
                        n++;
                    end
                    check(overflow === 1'b1, "overflow flag did not rise");
                end
                default: wait_frames(cfg_frames[t]);
            endcase
            if (t == T_LEVELS) begin
                check(durations_checked >= cfg_frames[t], "too few half-periods were measured");
            end
            if (t == T_TRIGGER) begin
                check(trig_pulses >= 2, "too few step triggers to measure their spacing");
            end
            $display("Test %0d (%s) finished: %0d frames checked, %0d errors.",
                     t, test_name[t], frames_checked, errors - err_start);
        end

        $display("Tests run: %0d, checks: %0d, errors: %0d.", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : tb_mod_dac_top

//--- all.f
+incdir+source
source/mod_pkg.sv
source/dac_pkg.sv
source/square_mod_gen.sv
source/sample_fifo.sv
source/dac_serializer.sv
source/mod_dac_top.sv
dv/tb_clk_gen.sv
dv/tb_mod_dac_top.sv

//--- Bender.yml
package:
  name: mod_dac

sources:
  - include_dirs:
      - source
    files:
      - source/mod_pkg.sv
      - source/dac_pkg.sv
      - source/square_mod_gen.sv
      - source/sample_fifo.sv
      - source/dac_serializer.sv
      - source/mod_dac_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_mod_dac_top.sv
